// ==== source/fir_num_pkg.sv ====
// all arithmetic types are signed two's complement, and acc_t allows growth for 32 taps at most
package fir_num_pkg;

    localparam int SAMPLE_W = 16;                 // one input word
    localparam int COEF_W   = 18;                 // coefficient width
    localparam int PROD_W   = SAMPLE_W + COEF_W;  // full product, no truncation
    localparam int GROWTH_W = 5;                  // log2 of the largest tap count
    localparam int ACC_W    = PROD_W + GROWTH_W;
    localparam int OUT_W    = 16;

    // input sample as it arrives on the stream
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // run-time loadable filter coefficient
    typedef logic signed [COEF_W-1:0] coef_t;

    // one tap's sample times coefficient
    typedef logic signed [PROD_W-1:0] product_t;

    // full-precision sum of all tap products
    typedef logic signed [ACC_W-1:0] acc_t;

    // rounded and saturated result
    typedef logic signed [OUT_W-1:0] out_t;

endpackage

// ==== source/fir_coef_pkg.sv ====
// defaults cover the 28-tap reference set, entries beyond it are zero, at most 32 taps fit the address
package fir_coef_pkg;

    import fir_num_pkg::*;

    localparam int MAX_TAPS = 32;

    // index into the coefficient register file
    typedef logic [$clog2(MAX_TAPS)-1:0] coef_addr_t;

    // tap 0 multiplies the newest sample
    localparam coef_t COEF_DEFAULT [MAX_TAPS] = '{
        18'sd560,    18'sd608,    -18'sd120,   -18'sd354,
        -18'sd34,    18'sd538,    18'sd40,     -18'sd560,
        -18'sd250,   18'sd692,    18'sd412,    -18'sd710,
        -18'sd704,   18'sd740,    18'sd1014,   -18'sd662,
        -18'sd1436,  18'sd514,    18'sd1936,   -18'sd198,
        -18'sd2608,  -18'sd354,   18'sd3572,   18'sd1438,
        -18'sd5354,  -18'sd4176,  18'sd11198,  18'sd27938,
        18'sd0,      18'sd0,      18'sd0,      18'sd0
    };

endpackage

// ==== source/shift_reg.sv ====
// DELAY must be at least 1, every stage clears on reset so no stale strobe leaves the chain
module shift_reg #(
    parameter int DELAY = 2
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic data_i,
    output logic data_o
);

    logic [DELAY-1:0] stage_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage_q <= '0;
        end else begin
            stage_q[0] <= data_i;
            for (int i = 1; i < DELAY; i++) begin
                stage_q[i] <= stage_q[i-1];   // one cycle per stage
            end
        end
    end

    assign data_o = stage_q[DELAY-1];

endmodule

// ==== source/coef_bank.sv ====
// TAP_NUM must be even and no larger than MAX_TAPS, writes to addresses at or above TAP_NUM are dropped
module coef_bank
    import fir_num_pkg::*;
    import fir_coef_pkg::*;
#(
    parameter int TAP_NUM = 28
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       we_i,
    input  coef_addr_t addr_i,
    input  coef_t      data_i,
    output coef_t      coefs_o [TAP_NUM]
);

    if (TAP_NUM > MAX_TAPS || TAP_NUM % 2 != 0) begin : g_bad_taps
        $error("TAP_NUM must be even and at most %0d", MAX_TAPS);
    end

    // each register decodes its own address, so out-of-range writes hit nothing
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < TAP_NUM; i++) begin
            if (rst_i) begin
                coefs_o[i] <= COEF_DEFAULT[i];
            end else if (we_i && addr_i == coef_addr_t'(i)) begin
                coefs_o[i] <= data_i;     // visible to the filter on the next cycle
            end
        end
    end

endmodule

// ==== source/fir_filter.sv ====
// result emerges 1 + clog2(TAP_NUM) cycles after the accepting edge, coefficient changes apply at once
module fir_filter
    import fir_num_pkg::*;
#(
    parameter int TAP_NUM = 28
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     valid_i,
    input  sample_t  sample_i,
    input  coef_t    coefs_i [TAP_NUM],
    output logic     sum_valid_o,
    output acc_t     sum_o
);

    localparam int DEPTH  = $clog2(TAP_NUM);
    localparam int LEAVES = 2 ** DEPTH;

    sample_t  taps_q [TAP_NUM];
    product_t prod_q [TAP_NUM];
    logic     load_q;                        // delay line holds a fresh sample

    // the tap line moves only on accepted samples, so idle cycles leave history intact
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            load_q <= 1'b0;
            for (int i = 0; i < TAP_NUM; i++) begin
                taps_q[i] <= '0;
            end
        end else begin
            load_q <= valid_i;
            if (valid_i) begin
                taps_q[0] <= sample_i;
                for (int i = 1; i < TAP_NUM; i++) begin
                    taps_q[i] <= taps_q[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < TAP_NUM; i++) begin
            prod_q[i] <= taps_q[i] * coefs_i[i];
        end
    end

    // level 0 holds the products padded up to a power of two, each later level is one register
    for (genvar l = 0; l <= DEPTH; l++) begin : g_lvl
        acc_t node [LEAVES >> l];
        for (genvar i = 0; i < (LEAVES >> l); i++) begin : g_node
            if (l == 0) begin : g_leaf
                if (i < TAP_NUM) begin : g_prod
                    assign node[i] = prod_q[i];          // sign extends into acc_t
                end else begin : g_pad
                    assign node[i] = '0;
                end
            end else begin : g_add
                always_ff @(posedge clk_i) begin
                    node[i] <= g_lvl[l-1].node[2*i] + g_lvl[l-1].node[2*i+1];
                end
            end
        end
    end

    assign sum_o = g_lvl[DEPTH].node[0];

    // covers the product stage and every tree level
    shift_reg #(
        .DELAY (1 + DEPTH)
    ) valid_dly_i (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .data_i (load_q),
        .data_o (sum_valid_o)
    );

endmodule

// ==== source/out_scaler.sv ====
// SHIFT must be at least 1, rounding is half up and out-of-range results clamp with sat_o set
module out_scaler
    import fir_num_pkg::*;
#(
    parameter int SHIFT = 17
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic valid_i,
    input  acc_t sum_i,
    output logic valid_o,
    output out_t data_o,
    output logic sat_o
);

    localparam int RW = $bits(acc_t) + 1;    // one guard bit so rounding cannot wrap

    localparam logic signed [RW-1:0] ROUND   = RW'(1) << (SHIFT - 1);
    localparam logic signed [RW-1:0] OUT_MAX = 2 ** ($bits(out_t) - 1) - 1;
    localparam logic signed [RW-1:0] OUT_MIN = -(2 ** ($bits(out_t) - 1));

    logic signed [RW-1:0] sum_ext;
    logic signed [RW-1:0] scaled;
    out_t                 clamped;
    logic                 clip;

    assign sum_ext = sum_i;

    always_comb begin
        scaled  = (sum_ext + ROUND) >>> SHIFT;
        clip    = 1'b1;
        clamped = out_t'(scaled);
        if (scaled > OUT_MAX) begin
            clamped = out_t'(OUT_MAX);
        end else if (scaled < OUT_MIN) begin
            clamped = out_t'(OUT_MIN);
        end else begin
            clip = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            sat_o   <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                sat_o <= clip;               // holds until the next result
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            data_o <= clamped;
        end
    end

endmodule

// ==== source/fir_top.sv ====
// valid-only stream with no stall, out_valid_o follows each accepted sample by 2 + clog2(TAP_NUM) cycles
module fir_top
    import fir_num_pkg::*;
    import fir_coef_pkg::*;
#(
    parameter int TAP_NUM = 28,
    parameter int SHIFT   = 17
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       sample_valid_i,
    input  sample_t    sample_i,
    input  logic       coef_we_i,
    input  coef_addr_t coef_addr_i,
    input  coef_t      coef_data_i,
    output logic       out_valid_o,
    output out_t       out_data_o,
    output logic       out_sat_o
);

    coef_t coefs [TAP_NUM];
    logic  sum_valid;
    acc_t  sum;

    coef_bank #(
        .TAP_NUM (TAP_NUM)
    ) coef_bank_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .we_i    (coef_we_i),
        .addr_i  (coef_addr_i),
        .data_i  (coef_data_i),
        .coefs_o (coefs)
    );

    fir_filter #(
        .TAP_NUM (TAP_NUM)
    ) fir_filter_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (sample_valid_i),
        .sample_i    (sample_i),
        .coefs_i     (coefs),
        .sum_valid_o (sum_valid),
        .sum_o       (sum)
    );

    out_scaler #(
        .SHIFT (SHIFT)
    ) out_scaler_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (sum_valid),
        .sum_i   (sum),
        .valid_o (out_valid_o),
        .data_o  (out_data_o),
        .sat_o   (out_sat_o)
    );

endmodule

// ==== testbench/fir_chk.sv ====
// assumes TAP_NUM equals the value of the bound fir_top, timing checks are skipped while rst_i is high
module fir_chk
    import fir_coef_pkg::*;
#(
    parameter int TAP_NUM = 28
) (
    input logic       clk_i,
    input logic       rst_i,
    input logic       sample_valid_i,
    input logic       coef_we_i,
    input coef_addr_t coef_addr_i,
    input logic       out_valid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY = 2 + $clog2(TAP_NUM);   // accepting edge to the edge that raises out_valid_o

    a_valid_known: assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown(out_valid_o))
        else $error("out_valid_o is unknown");

    // out_valid_o rises on an edge, so the sampled value shows it one edge later
    a_valid_after_sample: assert property (@(posedge clk_i) disable iff (rst_i)
        sample_valid_i |=> ##LATENCY out_valid_o)
        else $error("out_valid_o missing %0d cycles after an accepted sample", LATENCY);

    a_no_valid_without_sample: assert property (@(posedge clk_i) disable iff (rst_i)
        !sample_valid_i |=> ##LATENCY !out_valid_o)
        else $error("out_valid_o high with no sample accepted %0d cycles before", LATENCY);

    a_quiet_in_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
        else $error("out_valid_o high during reset");

    a_write_addr_known: assert property (@(posedge clk_i) disable iff (rst_i)
        coef_we_i |-> !$isunknown(coef_addr_i))
        else $error("coefficient write with an unknown address");

endmodule

// ==== testbench/fir_tb.sv ====
// drives fir_top with 28 taps and SHIFT 17, coefficients are only rewritten while no sample is in flight
module fir_tb
    import fir_num_pkg::*;
    import fir_coef_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TAP_NUM     = 28;
    localparam int SHIFT       = 17;
    localparam int DEPTH       = $clog2(TAP_NUM);
    localparam int LATENCY     = 2 + DEPTH;
    localparam int RST_CYCLES  = 16;
    localparam int IDLE_CYCLES = 10;
    localparam int RAND_LEN    = 300;
    localparam int FULL_LEN    = 80;
    localparam int NEW_LEN     = 200;
    localparam int DRAIN_MAX   = LATENCY + 4;
    localparam int STIM_CYCLES = RST_CYCLES + IDLE_CYCLES + TAP_NUM + RAND_LEN + TAP_NUM
                                 + FULL_LEN + TAP_NUM + 1 + NEW_LEN + 4 * DRAIN_MAX;
    localparam int CYCLE_LIMIT = STIM_CYCLES + LATENCY + 100;
    localparam logic [15:0] SEED = 16'd14139;
    localparam longint OUT_MAX = (longint'(1) <<< ($bits(out_t) - 1)) - 1;
    localparam longint OUT_MIN = -(longint'(1) <<< ($bits(out_t) - 1));

    logic       clk_i = 1'b0;
    logic       rst_i;
    logic       sample_valid_i;
    sample_t    sample_i;
    logic       coef_we_i;
    coef_addr_t coef_addr_i;
    coef_t      coef_data_i;
    logic       out_valid_o;
    out_t       out_data_o;
    logic       out_sat_o;

    logic [15:0] lfsr_state = SEED;
    coef_t       model_coef [TAP_NUM];
    sample_t     hist [TAP_NUM];           // hist[0] is the newest accepted sample
    out_t        exp_data_q [$];
    logic        exp_sat_q [$];
    int          acc_count = 0;
    int          out_count = 0;
    int          sat_count = 0;
    int          cycle_count = 0;

    fir_top #(
        .TAP_NUM (TAP_NUM),
        .SHIFT   (SHIFT)
    ) fir_top_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .coef_we_i      (coef_we_i),
        .coef_addr_i    (coef_addr_i),
        .coef_data_i    (coef_data_i),
        .out_valid_o    (out_valid_o),
        .out_data_o     (out_data_o),
        .out_sat_o      (out_sat_o)
    );

    bind fir_top fir_chk #(.TAP_NUM(TAP_NUM)) fir_chk_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .sample_valid_i (sample_valid_i),
        .coef_we_i      (coef_we_i),
        .coef_addr_i    (coef_addr_i),
        .out_valid_o    (out_valid_o)
    );

    always #50 clk_i = ~clk_i;

    // x^16 + x^14 + x^13 + x^11 + 1 in Galois form
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input out_t exp, input out_t got);
        if (got !== exp) begin
            $display("ERROR at %0t: out_data_o is %0d, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sat(input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERROR at %0t: out_sat_o is %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input int exp, input int got);
        if (got != exp) begin
            $display("ERROR at %0t: %0d outputs seen, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    // sum of products, then round half up, shift and clamp to the output range
    task automatic predict(input sample_t data);
        longint acc;
        longint scaled;
        logic   sat;
        for (int i = TAP_NUM - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = data;
        acc = 0;
        for (int i = 0; i < TAP_NUM; i++) begin
            acc += longint'(hist[i]) * longint'(model_coef[i]);
        end
        scaled = (acc + (longint'(1) <<< (SHIFT - 1))) >>> SHIFT;
        sat = (scaled > OUT_MAX) || (scaled < OUT_MIN);
        if (scaled > OUT_MAX) begin
            scaled = OUT_MAX;
        end else if (scaled < OUT_MIN) begin
            scaled = OUT_MIN;
        end
        exp_data_q.push_back(out_t'(scaled));
        exp_sat_q.push_back(sat);
    endtask

    task automatic send_sample(input logic valid, input sample_t data);
        @(negedge clk_i);
        coef_we_i      = 1'b0;
        sample_valid_i = valid;
        sample_i       = data;
        if (valid) begin
            predict(data);
            acc_count++;
        end
    endtask

    task automatic send_random();
        logic [31:0] r;
        logic        v;
        sample_t     s;
        r = take_bits(1);
        v = r[0];
        r = take_bits(16);
        s = sample_t'(r[15:0]);
        send_sample(v, s);
    endtask

    task automatic write_coef(input coef_addr_t addr, input coef_t data);
        @(negedge clk_i);
        sample_valid_i = 1'b0;
        coef_we_i      = 1'b1;
        coef_addr_i    = addr;
        coef_data_i    = data;
        if (int'(addr) < TAP_NUM) begin
            model_coef[addr] = data;           // the DUT drops writes beyond the last tap
        end
    endtask

    task automatic wait_drain();
        @(negedge clk_i);
        sample_valid_i = 1'b0;
        coef_we_i      = 1'b0;
        while (exp_data_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (2) @(negedge clk_i);
    endtask

    always @(negedge clk_i) begin
        if (!rst_i && out_valid_o === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                $display("ERROR at %0t: out_valid_o high with no sample in flight", $time);
                abort_run();
            end else begin
                check_data(exp_data_q.pop_front(), out_data_o);
                check_sat(exp_sat_q.pop_front(), out_sat_o);
                out_count++;
                if (out_sat_o === 1'b1) begin
                    sat_count++;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("the run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin
        logic [31:0] r;
        rst_i          = 1'b1;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        coef_we_i      = 1'b0;
        coef_addr_i    = '0;
        coef_data_i    = '0;
        for (int i = 0; i < TAP_NUM; i++) begin
            model_coef[i] = COEF_DEFAULT[i];
            hist[i]       = '0;
        end
        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        repeat (IDLE_CYCLES) @(negedge clk_i);
        check_count(0, out_count);             // nothing may come out before the first sample

        send_sample(1'b1, sample_t'(1000));    // impulse walks through the taps in order
        repeat (TAP_NUM - 1) send_sample(1'b1, '0);
        wait_drain();

        repeat (RAND_LEN) send_random();
        wait_drain();

        // the default set has too little gain to clip, so load the largest positive value
        for (int i = 0; i < TAP_NUM; i++) begin
            write_coef(coef_addr_t'(i), coef_t'(131071));
        end
        repeat (FULL_LEN / 2) send_sample(1'b1, sample_t'(32767));
        repeat (FULL_LEN / 2) send_sample(1'b1, sample_t'(-32768));
        wait_drain();
        if (sat_count == 0) begin
            $display("the full-scale run never saturated the output");
            abort_run();
        end

        for (int i = 0; i < TAP_NUM; i++) begin
            r = take_bits(18);
            write_coef(coef_addr_t'(i), coef_t'(r[17:0]));
        end
        r = take_bits(18);
        write_coef(coef_addr_t'(30), coef_t'(r[17:0]));
        repeat (NEW_LEN) send_random();
        wait_drain();

        check_count(acc_count, out_count);
        if (exp_data_q.size() != 0) begin
            $display("%0d expected outputs never appeared", exp_data_q.size());
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
source/fir_num_pkg.sv
source/fir_coef_pkg.sv
source/shift_reg.sv
source/coef_bank.sv
source/fir_filter.sv
source/out_scaler.sv
source/fir_top.sv
testbench/fir_chk.sv
testbench/fir_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module fir_tb -f flist.f -o fir_sim

status=0
./obj_dir/fir_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, exit status $status"
exit 1
